// ==== Makefile ====
VERILATOR    ?= verilator
TOP          := cpu_tb
FILELIST     := all.f
OBJ_DIR      := obj_dir
LOG          := sim.log
COMMON_FLAGS := --timing --assert --top-module $(TOP) -f $(FILELIST)
LINT_FLAGS   := --lint-only
BUILD_FLAGS  := --binary -j 0 --Mdir $(OBJ_DIR)
RUN_FLAGS    := +verilator+error+limit+100
PASS_TEXT    := Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(COMMON_FLAGS)

sim:
	$(VERILATOR) $(BUILD_FLAGS) $(COMMON_FLAGS)
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	grep -q "^$(PASS_TEXT)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== all.f ====
design/cpu_pkg.sv
design/pipe_if.sv
design/imem.sv
design/regfile.sv
design/id_stage.sv
design/ex_stage.sv
design/wb_stage.sv
design/cpu.sv
verif/cpu_assertions.sv
verif/cpu_tb.sv

// ==== design/cpu.sv ====
`timescale 1ns/1ps

module cpu #(
    parameter int                       imem_words = 256,
    parameter logic [cpu_pkg::xlen-1:0] reset_pc   = '0
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           prog_we,     // Program load strobe
    input  logic [7:0]                     prog_addr,   // Word index
    input  logic [cpu_pkg::xlen-1:0]       prog_data,
    input  logic                           start,
    output logic                           retire_valid,
    output logic [cpu_pkg::reg_addr_w-1:0] retire_rd,
    output logic [cpu_pkg::xlen-1:0]       retire_data,
    output logic                           halted
);
    import cpu_pkg::*;

    localparam int imem_aw = $clog2(imem_words);  // At most 8 with the load port

    logic [xlen-1:0]       fetch_addr;
    logic [xlen-1:0]       inst;
    logic [reg_addr_w-1:0] rf_raddr1, rf_raddr2;
    logic [xlen-1:0]       rf_rdata1, rf_rdata2;
    logic                  rf_we;
    logic [reg_addr_w-1:0] rf_waddr;
    logic [xlen-1:0]       rf_wdata;
    logic                  redirect;
    logic [xlen-1:0]       redirect_pc;

    ex_bus ex_if ();
    wb_bus wb_if ();

    imem #(.words(imem_words)) imem_i (
        .clk   (clk),
        .we    (prog_we),
        .waddr (prog_addr[imem_aw-1:0]),
        .wdata (prog_data),
        .raddr (fetch_addr[imem_aw+1:2]),  // Byte to word address
        .rdata (inst)
    );

    regfile regfile_i (
        .clk    (clk),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    id_stage #(.reset_pc(reset_pc)) id_stage_i (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .fetch_addr  (fetch_addr),
        .inst        (inst),
        .rf_raddr1   (rf_raddr1),
        .rf_raddr2   (rf_raddr2),
        .rf_rdata1   (rf_rdata1),
        .rf_rdata2   (rf_rdata2),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .halted      (halted),
        .ex          (ex_if.id),
        .fwd         (wb_if.fwd)
    );

    ex_stage ex_stage_i (
        .clk         (clk),
        .rst         (rst),
        .in          (ex_if.ex),
        .out         (wb_if.ex),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    wb_stage wb_stage_i (
        .wb           (wb_if.wb),
        .rf_we        (rf_we),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

endmodule

// ==== design/cpu_pkg.sv ====
package cpu_pkg;

    // Datapath widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // Major opcodes of the supported subset
    localparam logic [6:0] opc_alu_r  = 7'b0110011;
    localparam logic [6:0] opc_alu_i  = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [xlen-1:0] inst_ecall = 32'h0000_0073;  // Whole word, no fields

    // Operation class after decode
    typedef enum logic [2:0] {
        op_alu_r,
        op_alu_i,
        op_lui,
        op_beq,
        op_bne,
        op_jal,
        op_ecall,
        op_illegal   // Unknown encodings, retire as a bubble
    } op_e;

    // ALU function select
    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt      // Signed compare, 0 or 1
    } alu_e;

    // Everything execute needs besides the operand values
    typedef struct packed {
        op_e                   op;
        alu_e                  alu;
        logic [reg_addr_w-1:0] rd;
        logic                  writes_rd;  // Produces a register result
        logic [xlen-1:0]       imm;        // Sign-extended, format already resolved
        logic [xlen-1:0]       pc;         // Address of this instruction
    } dec_op_t;

endpackage

// ==== design/ex_stage.sv ====
`timescale 1ns/1ps

module ex_stage (
    input  logic                     clk,
    input  logic                     rst,
    ex_bus.ex                        in,
    wb_bus.ex                        out,
    output logic                     redirect,     // Same cycle as the branch
    output logic [cpu_pkg::xlen-1:0] redirect_pc
);
    import cpu_pkg::*;

    logic [xlen-1:0] alu_b;     // Second ALU operand
    logic [xlen-1:0] alu_out;
    logic [xlen-1:0] result;
    logic            taken;
    logic            produces;  // Live write to a real register

    assign alu_b = (in.dec.op == op_alu_i) ? in.dec.imm : in.rs2_val;

    always_comb begin
        case (in.dec.alu)
            alu_add: alu_out = in.rs1_val + alu_b;
            alu_sub: alu_out = in.rs1_val - alu_b;
            alu_and: alu_out = in.rs1_val & alu_b;
            alu_or:  alu_out = in.rs1_val | alu_b;
            alu_xor: alu_out = in.rs1_val ^ alu_b;
            alu_slt: alu_out = {{(xlen-1){1'b0}}, $signed(in.rs1_val) < $signed(alu_b)};
            default: alu_out = '0;
        endcase
    end

    // Result select by op class
    always_comb begin
        case (in.dec.op)
            op_lui:  result = in.dec.imm;
            op_jal:  result = in.dec.pc + 32'd4;  // Link address
            default: result = alu_out;
        endcase
    end

    // Branch resolve
    always_comb begin
        case (in.dec.op)
            op_beq:  taken = in.rs1_val == in.rs2_val;
            op_bne:  taken = in.rs1_val != in.rs2_val;
            op_jal:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign redirect    = in.valid && taken;
    assign redirect_pc = in.dec.pc + in.dec.imm;  // B and J immediates are PC-relative

    assign produces = in.valid && in.dec.writes_rd && in.dec.rd != '0;

    // Loop back to decode for the next instruction's operands
    assign in.fwd_valid = produces;
    assign in.fwd_rd    = in.dec.rd;
    assign in.fwd_data  = result;

    always_ff @(posedge clk) begin
        if (rst) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= produces;
        end
    end

    always_ff @(posedge clk) begin
        out.rd     <= in.dec.rd;
        out.result <= result;
    end

endmodule

// ==== design/id_stage.sv ====
`timescale 1ns/1ps

module id_stage #(
    parameter logic [cpu_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           start,        // One-cycle go strobe
    output logic [cpu_pkg::xlen-1:0]       fetch_addr,   // Byte address
    input  logic [cpu_pkg::xlen-1:0]       inst,         // Word fetched last cycle
    output logic [cpu_pkg::reg_addr_w-1:0] rf_raddr1,
    output logic [cpu_pkg::reg_addr_w-1:0] rf_raddr2,
    input  logic [cpu_pkg::xlen-1:0]       rf_rdata1,
    input  logic [cpu_pkg::xlen-1:0]       rf_rdata2,
    input  logic                           redirect,     // Taken branch or JAL in execute
    input  logic [cpu_pkg::xlen-1:0]       redirect_pc,
    output logic                           halted,
    ex_bus.id                              ex,
    wb_bus.fwd                             fwd
);
    import cpu_pkg::*;

    logic            running;     // Fetch enabled
    logic [xlen-1:0] pc;          // Address fetched this cycle
    logic [xlen-1:0] dec_pc;      // Address of the word on inst
    logic            inst_valid;  // Word on inst is live
    logic            is_ecall;    // Live ECALL in decode
    dec_op_t         dec;
    logic [xlen-1:0] imm_i, imm_u, imm_b, imm_j;

    // Youngest producer wins, register file last
    function automatic logic [xlen-1:0] pick_operand(
        input logic [reg_addr_w-1:0] rs,
        input logic [xlen-1:0]       rf_val,
        input logic                  ex_v,
        input logic [reg_addr_w-1:0] ex_rd,
        input logic [xlen-1:0]       ex_data,
        input logic                  wb_v,
        input logic [reg_addr_w-1:0] wb_rd,
        input logic [xlen-1:0]       wb_data
    );
        logic [xlen-1:0] val;
        val = rf_val;
        if (wb_v && wb_rd == rs) val = wb_data;
        if (ex_v && ex_rd == rs) val = ex_data;  // Producers never carry rd of x0
        return val;
    endfunction

    assign fetch_addr = pc;
    assign rf_raddr1  = inst[19:15];
    assign rf_raddr2  = inst[24:20];  // Immediate bits for I-type, harmless

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        dec.op        = op_illegal;  // Default bubble
        dec.alu       = alu_add;
        dec.rd        = inst[11:7];
        dec.writes_rd = 1'b0;
        dec.imm       = imm_i;
        dec.pc        = dec_pc;
        case (inst[6:0])
            opc_alu_r: begin
                dec.op        = op_alu_r;
                dec.writes_rd = 1'b1;
                case ({inst[31:25], inst[14:12]})
                    {7'b0000000, 3'b000}: dec.alu = alu_add;
                    {7'b0100000, 3'b000}: dec.alu = alu_sub;
                    {7'b0000000, 3'b111}: dec.alu = alu_and;
                    {7'b0000000, 3'b110}: dec.alu = alu_or;
                    {7'b0000000, 3'b100}: dec.alu = alu_xor;
                    {7'b0000000, 3'b010}: dec.alu = alu_slt;
                    default: begin
                        dec.op        = op_illegal;
                        dec.writes_rd = 1'b0;
                    end
                endcase
            end
            opc_alu_i: begin
                dec.op        = op_alu_i;
                dec.writes_rd = 1'b1;
                case (inst[14:12])
                    3'b000:  dec.alu = alu_add;  // ADDI
                    3'b111:  dec.alu = alu_and;  // ANDI
                    3'b110:  dec.alu = alu_or;   // ORI
                    3'b100:  dec.alu = alu_xor;  // XORI
                    default: begin
                        dec.op        = op_illegal;
                        dec.writes_rd = 1'b0;
                    end
                endcase
            end
            opc_lui: begin
                dec.op        = op_lui;
                dec.writes_rd = 1'b1;
                dec.imm       = imm_u;
            end
            opc_branch: begin
                dec.imm = imm_b;
                if (inst[14:12] == 3'b000)      dec.op = op_beq;
                else if (inst[14:12] == 3'b001) dec.op = op_bne;
            end
            opc_jal: begin
                dec.op        = op_jal;
                dec.writes_rd = 1'b1;
                dec.imm       = imm_j;
            end
            default: begin
                if (inst == inst_ecall) dec.op = op_ecall;
            end
        endcase
    end

    assign is_ecall = inst_valid && !redirect && dec.op == op_ecall;

    // Control state
    always_ff @(posedge clk) begin
        if (rst) begin
            running    <= 1'b0;
            pc         <= reset_pc;
            inst_valid <= 1'b0;
            halted     <= 1'b0;
            ex.valid   <= 1'b0;
        end else begin
            ex.valid <= inst_valid && !redirect;  // Flush the decode slot
            if (redirect) begin
                pc         <= redirect_pc;
                inst_valid <= 1'b0;  // Kill the word fetched this cycle
            end else if (is_ecall) begin
                running    <= 1'b0;
                inst_valid <= 1'b0;  // Younger fetch discarded
                halted     <= 1'b1;  // High as ECALL enters execute
            end else if (running) begin
                pc         <= pc + 32'd4;
                inst_valid <= 1'b1;
            end else begin
                inst_valid <= 1'b0;
                if (start && !halted) running <= 1'b1;  // First fetch next cycle
            end
        end
    end

    // Payload, qualified by the valids
    always_ff @(posedge clk) begin
        dec_pc     <= pc;  // imem returns this word next cycle
        ex.dec     <= dec;
        ex.rs1_val <= pick_operand(rf_raddr1, rf_rdata1, ex.fwd_valid, ex.fwd_rd,
                                   ex.fwd_data, fwd.valid, fwd.rd, fwd.result);
        ex.rs2_val <= pick_operand(rf_raddr2, rf_rdata2, ex.fwd_valid, ex.fwd_rd,
                                   ex.fwd_data, fwd.valid, fwd.rd, fwd.result);
    end

endmodule

// ==== design/imem.sv ====
`timescale 1ns/1ps

module imem #(
    parameter int words = 256
) (
    input  logic                       clk,
    input  logic                       we,     // Load strobe
    input  logic [$clog2(words)-1:0]   waddr,  // Word index
    input  logic [cpu_pkg::xlen-1:0]   wdata,
    input  logic [$clog2(words)-1:0]   raddr,  // Fetch word index
    output logic [cpu_pkg::xlen-1:0]   rdata   // Valid the cycle after raddr
);
    import cpu_pkg::*;

    logic [xlen-1:0] mem [words];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];  // Registered read, one cycle
    end

endmodule

// ==== design/pipe_if.sv ====
`timescale 1ns/1ps

// Decode to execute, plus the execute result looped back for forwarding
interface ex_bus;
    import cpu_pkg::*;

    logic            valid;    // Live instruction in execute
    dec_op_t         dec;
    logic [xlen-1:0] rs1_val;  // Operands after forwarding
    logic [xlen-1:0] rs2_val;

    logic                  fwd_valid;  // Execute result this cycle targets fwd_rd
    logic [reg_addr_w-1:0] fwd_rd;
    logic [xlen-1:0]       fwd_data;

    modport id (output valid, dec, rs1_val, rs2_val, input fwd_valid, fwd_rd, fwd_data);
    modport ex (input valid, dec, rs1_val, rs2_val, output fwd_valid, fwd_rd, fwd_data);
endinterface

// Execute to writeback, also tapped by decode
interface wb_bus;
    import cpu_pkg::*;

    logic                  valid;   // Only set for a nonzero rd
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       result;

    modport ex  (output valid, rd, result);
    modport wb  (input valid, rd, result);
    modport fwd (input valid, rd, result);
endinterface

// ==== design/regfile.sv ====
`timescale 1ns/1ps

module regfile (
    input  logic                           clk,
    input  logic                           we,
    input  logic [cpu_pkg::reg_addr_w-1:0] waddr,
    input  logic [cpu_pkg::xlen-1:0]       wdata,
    input  logic [cpu_pkg::reg_addr_w-1:0] raddr1,
    input  logic [cpu_pkg::reg_addr_w-1:0] raddr2,
    output logic [cpu_pkg::xlen-1:0]       rdata1,
    output logic [cpu_pkg::xlen-1:0]       rdata2
);
    import cpu_pkg::*;

    logic [xlen-1:0] regs [1:31];  // No storage behind x0

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 reads zero, a same-cycle write wins over the stored value
    always_comb begin
        if (raddr1 == '0)                  rdata1 = '0;
        else if (we && waddr == raddr1)    rdata1 = wdata;
        else                               rdata1 = regs[raddr1];

        if (raddr2 == '0)                  rdata2 = '0;
        else if (we && waddr == raddr2)    rdata2 = wdata;
        else                               rdata2 = regs[raddr2];
    end

endmodule

// ==== design/wb_stage.sv ====
`timescale 1ns/1ps

module wb_stage (
    wb_bus.wb                              wb,
    output logic                           rf_we,
    output logic [cpu_pkg::reg_addr_w-1:0] rf_waddr,
    output logic [cpu_pkg::xlen-1:0]       rf_wdata,
    output logic                           retire_valid,
    output logic [cpu_pkg::reg_addr_w-1:0] retire_rd,
    output logic [cpu_pkg::xlen-1:0]       retire_data
);
    import cpu_pkg::*;

    logic commit;  // One write retires this cycle

    // Execute only raises valid for a real rd
    assign commit = wb.valid;

    // Register file write port
    assign rf_we    = commit;
    assign rf_waddr = wb.rd;
    assign rf_wdata = wb.result;

    // Retire trace from the same strobe as the write
    assign retire_valid = commit;
    assign retire_rd    = wb.rd;
    assign retire_data  = wb.result;

endmodule

// ==== verif/cpu_assertions.sv ====
`timescale 1ns/1ps

// Protocol checks on the core, bound into cpu
module cpu_assertions (
    input logic                           clk,
    input logic                           rst,
    input logic                           retire_valid,
    input logic [cpu_pkg::reg_addr_w-1:0] retire_rd,
    input logic                           halted,
    input logic                           redirect  // Internal strobe from execute
);
    int fail_count = 0;  // Summed into the end of run error count

    retire_rd_nonzero: assert property (@(posedge clk) disable iff (rst)
        retire_valid |-> retire_rd != '0)
    else begin
        $error("retire_valid raised for x0");
        fail_count++;
    end

    halted_sticky: assert property (@(posedge clk) disable iff (rst)
        halted |=> halted)
    else begin
        $error("halted fell outside reset");
        fail_count++;
    end

    // ECALL's one older instruction may retire with halted, nothing later
    no_late_retire: assert property (@(posedge clk) disable iff (rst)
        halted |=> !retire_valid)
    else begin
        $error("retire more than one cycle after halted");
        fail_count++;
    end

    redirect_single: assert property (@(posedge clk) disable iff (rst)
        redirect |=> !redirect)
    else begin
        $error("redirect held for two cycles");
        fail_count++;
    end

endmodule

bind cpu cpu_assertions cpu_assertions_i (
    .clk          (clk),
    .rst          (rst),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd),
    .halted       (halted),
    .redirect     (redirect)
);

// ==== verif/cpu_golden.txt ====
# P <word index> <instruction hex>  program, loaded in order
# W <rd> <data hex>  expected register writes, in retire order
P 0 00500093   # addi x1, x0, 5
P 1 FFD08113   # addi x2, x1, -3    x1 from execute
P 2 402081B3   # sub  x3, x1, x2    x1 from writeback, x2 from execute
P 3 0F01C213   # xori x4, x3, 0x0f0
P 4 123452B7   # lui  x5, 0x12345
P 5 0042E333   # or   x6, x5, x4
P 6 001373B3   # and  x7, x6, x1
P 7 FF800493   # addi x9, x0, -8
P 8 0014A433   # slt  x8, x9, x1    signed compare
P 9 00108013   # addi x0, x1, 1     no retire
P 10 00100533  # add  x10, x0, x1   x0 still reads zero
P 11 00209663  # bne  x1, x2, +12   taken
P 12 00100593  # addi x11, x0, 1    flushed
P 13 00200613  # addi x12, x0, 2    flushed
P 14 00208463  # beq  x1, x2, +8    not taken
P 15 1000E693  # ori  x13, x1, 0x100
P 16 00C0076F  # jal  x14, +12
P 17 00300793  # addi x15, x0, 3    flushed
P 18 00400813  # addi x16, x0, 4    flushed
P 19 00150663  # beq  x10, x1, +12  taken
P 20 00700913  # addi x18, x0, 7    flushed
P 21 00800993  # addi x19, x0, 8    flushed
P 22 00A70A33  # add  x20, x14, x10 link value from the register file
P 23 00FA7A93  # andi x21, x20, 0x00f
P 24 00000073  # ecall
P 25 00900B13  # addi x22, x0, 9    fetched after ecall, discarded
W 1 00000005
W 2 00000002
W 3 00000003
W 4 000000F3
W 5 12345000
W 6 123450F3
W 7 00000001
W 9 FFFFFFF8
W 8 00000001
W 10 00000005
W 13 00000105
W 14 00000044
W 20 00000049
W 21 00000009

// ==== verif/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb;
    import cpu_pkg::*;

    localparam int    reset_cycles = 16;
    localparam int    drain_cycles = 4;  // Window for late retires after halt
    localparam string golden_path  = "verif/cpu_golden.txt";

    logic                  clk       = 1'b0;
    logic                  rst       = 1'b1;
    logic                  prog_we   = 1'b0;
    logic [7:0]            prog_addr = '0;
    logic [xlen-1:0]       prog_data = '0;
    logic                  start     = 1'b0;
    logic                  retire_valid;
    logic [reg_addr_w-1:0] retire_rd;
    logic [xlen-1:0]       retire_data;
    logic                  halted;

    // Golden contents, program and expected retire order
    logic [7:0]            prog_addr_q[$];
    logic [xlen-1:0]       prog_word_q[$];
    logic [reg_addr_w-1:0] exp_rd_q[$];
    logic [xlen-1:0]       exp_data_q[$];
    logic [reg_addr_w-1:0] exp_rd;
    logic [xlen-1:0]       exp_data;

    int mismatch_count = 0;
    int trace_count    = 0;  // Retires with no place in the trace
    int other_count    = 0;
    int assert_count   = 0;
    int run_cycles     = 0;  // Cycles since start
    int cycle_limit    = 0;
    bit started        = 1'b0;
    bit halted_seen    = 1'b0;

    cpu #(.imem_words(256), .reset_pc(32'h0)) cpu_i (
        .clk          (clk),
        .rst          (rst),
        .prog_we      (prog_we),
        .prog_addr    (prog_addr),
        .prog_data    (prog_data),
        .start        (start),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .halted       (halted)
    );

    always #20 clk = ~clk;  // 40 ns period

    task automatic check_value(input logic [xlen-1:0] got, input logic [xlen-1:0] exp,
                               input string what);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH at time %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // P lines go to the program, W lines to the expected trace
    task automatic read_golden();
        int               fd;
        int               n;
        logic [7:0]       tag;
        logic [31:0]      col_a;
        logic [31:0]      col_b;
        logic [8*128-1:0] rest;
        fd = $fopen(golden_path, "r");
        if (fd == 0) begin
            other_count++;
            $display("Error: cannot open the golden file %s", golden_path);
            return;
        end
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "#") begin
                n = $fgets(rest, fd);  // Rest of a comment
            end else begin
                n = $fscanf(fd, "%d %h", col_a, col_b);
                if (n != 2) begin
                    other_count++;
                    $display("Error: golden line with tag %s has bad columns", tag);
                end else if (tag == "P") begin
                    prog_addr_q.push_back(col_a[7:0]);
                    prog_word_q.push_back(col_b);
                end else if (tag == "W") begin
                    exp_rd_q.push_back(col_a[reg_addr_w-1:0]);
                    exp_data_q.push_back(col_b);
                end else begin
                    other_count++;
                    $display("Error: unknown golden line tag %s", tag);
                end
            end
        end
        $fclose(fd);
    endtask

    // Program load runs alongside reset and may outlast it
    task automatic load_and_reset();
        int k;
        k = 0;
        while (k < reset_cycles || k < prog_word_q.size()) begin
            @(negedge clk);
            if (k < prog_word_q.size()) begin
                prog_we   = 1'b1;
                prog_addr = prog_addr_q[k];
                prog_data = prog_word_q[k];
            end else begin
                prog_we = 1'b0;
            end
            if (k == reset_cycles - 1) rst = 1'b0;  // 16 rising edges seen in reset
            k++;
        end
        @(negedge clk);
        prog_we = 1'b0;
    endtask

    // Retire monitor, mid-cycle sample
    always @(negedge clk) begin
        if (started) begin
            run_cycles++;
            if (retire_valid) begin
                if (halted_seen) begin
                    trace_count++;
                    $display("Error at time %0t: x%0d was written after the core halted",
                             $time, retire_rd);
                end else if (exp_rd_q.size() == 0) begin
                    trace_count++;
                    $display("Error at time %0t: write to x%0d beyond the expected trace",
                             $time, retire_rd);
                end else begin
                    exp_rd   = exp_rd_q.pop_front();
                    exp_data = exp_data_q.pop_front();
                    check_value({{(xlen-reg_addr_w){1'b0}}, retire_rd},
                                {{(xlen-reg_addr_w){1'b0}}, exp_rd}, "retire rd");
                    check_value(retire_data, exp_data, $sformatf("x%0d data", exp_rd));
                end
            end
            if (halted) halted_seen = 1'b1;  // First halted cycle may still retire
        end
    end

    initial begin
        read_golden();
        if (prog_word_q.size() == 0) begin
            other_count++;
            $display("Error: the golden file holds no program words");
        end
        cycle_limit = 4 * prog_word_q.size() + 64;
        load_and_reset();
        if (other_count == 0) begin
            @(posedge clk);
            started = 1'b1;
            @(negedge clk);
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;
            while (!halted_seen && run_cycles < cycle_limit) begin
                @(posedge clk);
            end
            repeat (drain_cycles) @(posedge clk);
            if (!halted_seen) begin
                other_count++;
                $display("Timeout: halted did not rise within %0d cycles of start",
                         cycle_limit);
            end else if (exp_rd_q.size() != 0) begin
                other_count++;
                $display("Error: core halted with %0d expected register writes missing",
                         exp_rd_q.size());
            end
        end
        assert_count = cpu_i.cpu_assertions_i.fail_count;
        $display("Errors: %0d mismatches, %0d trace, %0d other, %0d assertion",
                 mismatch_count, trace_count, other_count, assert_count);
        if (mismatch_count + trace_count + other_count + assert_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
